// File: files.f
+incdir+source
source/ex_pkg.sv
source/ex_fu_if.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_div.sv
source/ex_stage.sv
sim/ex_asserts.sv
sim/ex_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module ex_tb \
  -o ex_tb_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/ex_tb_sim > sim.log 2>&1
cat sim.log
grep -q "^No errors$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: sim/ex_asserts.sv
// Concurrent assertions on the execute stage handshake
// Reset state of WB valid, WB hold under back-pressure, no accept while a unit works

`include "ex_consts.svh"

module ex_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  id_valid_i,
  input logic                  mul_en_i,
  input logic                  div_en_i,
  input logic                  mul_res_valid_i,
  input logic                  div_res_valid_i,
  input logic                  ex_ready_i,
  input logic                  wb_ready_i,
  input logic                  wb_valid_i,
  input logic                  wb_rf_we_i,
  input logic [`EX_REG_AW-1:0] wb_rf_waddr_i,
  input logic [`EX_XLEN-1:0]   wb_rf_wdata_i,
  input logic                  wb_branch_taken_i
);

  int fail_cnt = 0;

  // WB valid cleared by reset
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !wb_valid_i)
    else begin
      fail_cnt++;
      $error("wb_valid_o high in reset");
    end

  // Payload frozen while WB stalls
  wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_i && !wb_ready_i |=> wb_valid_i &&
      $stable({wb_rf_we_i, wb_rf_waddr_i, wb_rf_wdata_i, wb_branch_taken_i}))
    else begin
      fail_cnt++;
      $error("WB payload changed under back-pressure");
    end

  // Multi-cycle unit selected and its result not yet valid
  busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_i && ((mul_en_i && !mul_res_valid_i) || (div_en_i && !div_res_valid_i))
      |-> !ex_ready_i)
    else begin
      fail_cnt++;
      $error("ex_ready_o high while a unit is busy");
    end

endmodule

bind ex_stage ex_asserts u_asserts (
  .clk               (clk),
  .rst_n             (rst_n),
  .id_valid_i        (id_valid_i),
  .mul_en_i          (mul_en_i),
  .div_en_i          (div_en_i),
  .mul_res_valid_i   (mul_if.res_valid),
  .div_res_valid_i   (div_if.res_valid),
  .ex_ready_i        (ex_ready_o),
  .wb_ready_i        (wb_ready_i),
  .wb_valid_i        (wb_valid_o),
  .wb_rf_we_i        (wb_rf_we_o),
  .wb_rf_waddr_i     (wb_rf_waddr_o),
  .wb_rf_wdata_i     (wb_rf_wdata_o),
  .wb_branch_taken_i (wb_branch_taken_o)
);

// File: sim/ex_tb.sv
// Testbench for the execute stage
// LFSR stimulus, reference model and in-order scoreboard
// Check task, cycle timeout and closing summary

`include "ex_consts.svh"

module ex_tb;
  import ex_pkg::*;

  localparam int XLEN    = `EX_XLEN;
  localparam int AW      = `EX_REG_AW;
  localparam int N_ALU   = 200;
  localparam int N_MUL   = 100;
  localparam int N_DIV   = 60;
  localparam int N_MIX   = 150;
  localparam int N_STALL = 40;
  localparam int N_TOTAL = N_ALU + N_MUL + N_DIV + N_MIX + N_STALL;
  // Worst case per instruction: full divide, idle gap and one long stall stretch
  localparam int PER_INSTR = `EX_DIV_STEPS + 3 + 4 + 36;
  localparam int TIMEOUT   = N_TOTAL * PER_INSTR * 2 + 1000;
  // Cycles allowed for the last results to leave the WB register
  localparam int DRAIN_LIMIT = 2 * PER_INSTR;

  typedef struct packed {
    logic            we;
    logic [AW-1:0]   waddr;
    logic [XLEN-1:0] data;
    logic            br;
  } wb_exp_t;

  logic clk;
  logic rst_n;
  logic id_valid_i;
  logic alu_en_i;
  logic mul_en_i;
  logic div_en_i;
  alu_op_e alu_op_i;
  mul_op_e mul_op_i;
  div_op_e div_op_i;
  logic [XLEN-1:0] operand_a_i;
  logic [XLEN-1:0] operand_b_i;
  logic rf_we_i;
  logic [AW-1:0] rf_waddr_i;
  logic ex_ready_o;
  logic wb_ready_i;
  logic wb_valid_o;
  logic wb_rf_we_o;
  logic [AW-1:0] wb_rf_waddr_o;
  logic [XLEN-1:0] wb_rf_wdata_o;
  logic wb_branch_taken_o;

  logic [31:0] lfsr_q = 32'h4e98;
  wb_exp_t     exp_q[$];
  wb_exp_t     held;
  logic        accepted = 1'b0;
  logic        prev_stall = 1'b0;
  logic        ready_high;
  string       cur_test = "reset";
  int ready_mode = 0;
  int stall_left = 0;
  int errors = 0;
  int test_errors = 0;
  int checks = 0;
  int tests_run = 0;
  int retired = 0;
  int assert_fails = 0;
  int cycle_cnt = 0;

  ex_stage u_ex_stage (.*);

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////

  // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // Corner values a quarter of the time
  function automatic logic [XLEN-1:0] pick_operand();
    logic [3:0] sel;
    sel = 4'(take_bits(4));
    case (sel)
      4'd0:    return '0;
      4'd1:    return {1'b1, {(XLEN-1){1'b0}}};
      4'd2:    return '1;
      4'd3:    return {1'b0, {(XLEN-1){1'b1}}};
      default: return take_bits(XLEN);
    endcase
  endfunction

  function automatic logic cmp_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b);
    case (op)
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_GEU:           return a >= b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $unsigned($signed(a) >>> b[4:0]);
      default: return {{(XLEN-1){1'b0}}, cmp_model(op, a, b)};
    endcase
  endfunction

  // Low or high word of the 64-bit product of the extended operands
  function automatic logic [XLEN-1:0] mul_model(input mul_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ax;
    logic [2*XLEN-1:0] bx;
    logic [2*XLEN-1:0] p;
    ax = (op == OP_MULH || op == OP_MULHSU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
    bx = (op == OP_MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    p  = ax * bx;
    return (op == OP_MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
  endfunction

  function automatic logic [XLEN-1:0] div_model(input div_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic sgn;
    logic want_rem;
    sgn      = (op == OP_DIV) || (op == OP_REM);
    want_rem = (op == OP_REM) || (op == OP_REMU);
    if (b == '0) return want_rem ? a : '1;
    // Signed overflow case
    if (sgn && a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) return want_rem ? '0 : a;
    if (sgn) begin
      return want_rem ? $unsigned($signed(a) % $signed(b)) : $unsigned($signed(a) / $signed(b));
    end
    return want_rem ? a % b : a / b;
  endfunction

  // Expected WB payload for the instruction on the ID inputs
  function automatic wb_exp_t expect_wb();
    wb_exp_t e;
    e.we    = rf_we_i;
    e.waddr = rf_waddr_i;
    e.br    = 1'b0;
    if (mul_en_i) begin
      e.data = mul_model(mul_op_i, operand_a_i, operand_b_i);
    end else if (div_en_i) begin
      e.data = div_model(div_op_i, operand_a_i, operand_b_i);
    end else begin
      e.data = alu_model(alu_op_i, operand_a_i, operand_b_i);
      e.br   = (alu_op_i >= ALU_EQ) && cmp_model(alu_op_i, operand_a_i, operand_b_i);
    end
    return e;
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor and scoreboard
  //////////////////////////////////////////////////

  // Sampled at the falling edge, where everything driven at the rising edge is settled
  always @(negedge clk) begin : monitor
    wb_exp_t e;
    if (rst_n) begin
      if (prev_stall) begin
        check("held valid", 32'(1'b1), 32'(wb_valid_o));
        check("held we", 32'(held.we), 32'(wb_rf_we_o));
        check("held waddr", 32'(held.waddr), 32'(wb_rf_waddr_o));
        check("held wdata", held.data, wb_rf_wdata_o);
        check("held branch", 32'(held.br), 32'(wb_branch_taken_o));
      end
      if (id_valid_i && !wb_ready_i) begin
        check("ex_ready_o under back-pressure", 32'(1'b0), 32'(ex_ready_o));
      end
      if (wb_valid_o && wb_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          test_errors++;
          $display("Error in %s: WB output with no instruction pending", cur_test);
        end else begin
          e = exp_q.pop_front();
          check("wdata", e.data, wb_rf_wdata_o);
          check("waddr", 32'(e.waddr), 32'(wb_rf_waddr_o));
          check("we", 32'(e.we), 32'(wb_rf_we_o));
          check("branch", 32'(e.br), 32'(wb_branch_taken_o));
          retired++;
        end
      end
      // Taken at the next rising edge
      if (id_valid_i && ex_ready_o) begin
        exp_q.push_back(expect_wb());
      end
      accepted   = id_valid_i && ex_ready_o;
      prev_stall = wb_valid_o && !wb_ready_i;
      held       = {wb_rf_we_o, wb_rf_waddr_o, wb_rf_wdata_o, wb_branch_taken_o};
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // One clock, then the WB ready pattern of the current mode
  task automatic tick();
    @(posedge clk);
    case (ready_mode)
      0: wb_ready_i <= 1'b1;
      1: wb_ready_i <= (take_bits(2) != 0);
      default: begin
        // Long low stretches, short high ones
        if (stall_left == 0) begin
          ready_high = !ready_high;
          stall_left = ready_high ? 1 + int'(take_bits(2)) : 1 + int'(take_bits(5));
        end
        stall_left--;
        wb_ready_i <= ready_high;
      end
    endcase
  endtask

  // Kind 0 ALU, 1 MUL, 2 DIV, 3 mixed; returns after the accepting edge
  task automatic issue(input int kind, input int idx);
    int unit;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    div_op_e dop;
    unit = (kind == 3) ? int'(take_bits(2)) : kind;
    a    = pick_operand();
    b    = pick_operand();
    dop  = div_op_e'(take_bits(2));
    // Equal operands now and then for EQ, GE and GEU
    if (unit != 1 && unit != 2 && take_bits(3) == 0) b = a;
    if (kind == 2 && idx % 8 == 0) begin
      a   = {1'b1, {(XLEN-1){1'b0}}};
      b   = '1;
      dop = OP_DIV;
    end
    if (kind == 2 && idx % 8 == 4) begin
      a   = {1'b1, {(XLEN-1){1'b0}}};
      b   = '1;
      dop = OP_REM;
    end
    if (kind == 2 && idx % 8 == 1) b = '0;
    alu_en_i    <= (unit == 0) || (unit == 3);
    mul_en_i    <= (unit == 1);
    div_en_i    <= (unit == 2);
    alu_op_i    <= alu_op_e'(take_bits(4));
    mul_op_i    <= mul_op_e'(take_bits(2));
    div_op_i    <= dop;
    operand_a_i <= a;
    operand_b_i <= b;
    rf_we_i     <= 1'(take_bits(1));
    rf_waddr_i  <= AW'(take_bits(AW));
    id_valid_i  <= 1'b1;
    tick();
    while (!accepted) tick();
  endtask

  task automatic run_test(input string name, input int kind, input int mode, input int count);
    int gap;
    int drain;
    cur_test    = name;
    test_errors = 0;
    retired     = 0;
    ready_mode  = mode;
    ready_high  = 1'b1;
    stall_left  = 0;
    for (int i = 0; i < count; i++) begin
      issue(kind, i);
      if (kind == 3) begin
        gap = int'(take_bits(2));
        if (gap != 0) begin
          id_valid_i <= 1'b0;
          repeat (gap) tick();
        end
      end
    end
    id_valid_i <= 1'b0;
    drain = 0;
    while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
      tick();
      drain++;
    end
    // Nothing lost, nothing extra
    check("retired count", 32'(count), 32'(retired));
    // Leftover entries belong to lost instructions
    exp_q.delete();
    tests_run++;
    $display("%-12s %0d instructions, %0d errors", name, count, test_errors);
  endtask

  initial begin : stimulus
    clk         = 1'b0;
    rst_n       = 1'b0;
    id_valid_i  = 1'b0;
    alu_en_i    = 1'b0;
    mul_en_i    = 1'b0;
    div_en_i    = 1'b0;
    alu_op_i    = ALU_ADD;
    mul_op_i    = OP_MUL;
    div_op_i    = OP_DIV;
    operand_a_i = '0;
    operand_b_i = '0;
    rf_we_i     = 1'b0;
    rf_waddr_i  = '0;
    wb_ready_i  = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    run_test("alu_random", 0, 0, N_ALU);
    run_test("mul_random", 1, 0, N_MUL);
    run_test("div_random", 2, 0, N_DIV);
    run_test("mixed_flow", 3, 1, N_MIX);
    run_test("wb_stall", 3, 2, N_STALL);
    assert_fails = u_ex_stage.u_asserts.fail_cnt;
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_run, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Cycle limit from the instruction count and the divider latency
  initial begin : watchdog
    while (cycle_cnt < TIMEOUT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("Errors found");
    $finish;
  end

endmodule

// File: source/ex_alu.sv
// Single-cycle ALU
// Shared adder for add, sub, set-less-than and branch compares
// Logic operations and barrel shifts

`include "ex_consts.svh"

module ex_alu (
  input  ex_pkg::alu_op_e      alu_op_i,
  input  logic [`EX_XLEN-1:0]  operand_a_i,
  input  logic [`EX_XLEN-1:0]  operand_b_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 cmp_result_o
);
  import ex_pkg::*;

  localparam int XLEN = `EX_XLEN;
  localparam int SHW  = $clog2(`EX_XLEN);

  logic            is_sub;
  logic            is_signed;
  logic [XLEN:0]   add_a;
  logic [XLEN:0]   add_b;
  logic [XLEN:0]   add_res;
  logic            lt;
  logic            eq;
  logic [SHW-1:0]  shamt;

  //////////////////////////////////////////////////
  // Adder and comparison
  //////////////////////////////////////////////////

  // Everything except ADD subtracts
  assign is_sub    = (alu_op_i != ALU_ADD);
  assign is_signed = (alu_op_i == ALU_SLT) || (alu_op_i == ALU_LT) ||
                     (alu_op_i == ALU_GE);

  // One extra bit, sign or zero, so the top bit of a - b is the less-than flag
  assign add_a   = {is_signed & operand_a_i[XLEN-1], operand_a_i};
  assign add_b   = {is_signed & operand_b_i[XLEN-1], operand_b_i};
  assign add_res = add_a + (is_sub ? ~add_b : add_b) + {{XLEN{1'b0}}, is_sub};

  assign lt = add_res[XLEN];
  // Difference is zero only for equal operands
  assign eq = (add_res[XLEN-1:0] == '0);

  always_comb begin
    unique case (alu_op_i)
      ALU_EQ:                     cmp_result_o = eq;
      ALU_NE:                     cmp_result_o = !eq;
      ALU_SLT, ALU_SLTU,
      ALU_LT, ALU_LTU:            cmp_result_o = lt;
      ALU_GE, ALU_GEU:            cmp_result_o = !lt;
      default:                    cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result mux with shifter
  //////////////////////////////////////////////////

  // Shift amount from the low bits of operand b
  assign shamt = operand_b_i[SHW-1:0];

  always_comb begin
    unique case (alu_op_i)
      ALU_ADD, ALU_SUB: result_o = add_res[XLEN-1:0];
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = operand_a_i << shamt;
      ALU_SRL:          result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:          result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Compares give the flag zero-extended
      default:          result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

// File: source/ex_consts.svh
// Execute stage constants
// Data width, register address width and divider iteration count

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Integer data path width
`define EX_XLEN 32

// Register file address width
`define EX_REG_AW 5

// One quotient bit per divider iteration
`define EX_DIV_STEPS `EX_XLEN

`endif

// File: source/ex_div.sv
// Iterative restoring divider
// Absolute values in, one quotient bit per cycle, sign correction at the end
// Divide-by-zero shortcut and most-negative by minus one handling
// Idle, run and done FSM with result hold

`include "ex_consts.svh"

module ex_div (
  input  logic   clk,
  input  logic   rst_n,
  ex_fu_if.unit  fu
);
  import ex_pkg::*;

  localparam int XLEN  = `EX_XLEN;
  localparam int STEPS = `EX_DIV_STEPS;
  localparam int CNT_W = $clog2(`EX_DIV_STEPS + 1);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

  div_state_e          state_q;
  logic [CNT_W-1:0]    cnt_q;
  logic [XLEN-1:0]     rem_q;
  logic [XLEN-1:0]     quo_q;
  logic [XLEN-1:0]     dvs_q;
  logic [XLEN-1:0]     result_q;
  logic                q_neg_q;
  logic                r_neg_q;

  logic                is_signed;
  logic                want_rem;
  logic                a_neg;
  logic                b_neg;
  logic                b_zero;
  logic [XLEN-1:0]     a_abs;
  logic [XLEN-1:0]     b_abs;
  logic                load;
  logic                zero_done;
  logic                step;
  logic                finish;
  logic [XLEN:0]       shifted;
  logic [XLEN+1:0]     trial;
  logic [XLEN-1:0]     q_fix;
  logic [XLEN-1:0]     r_fix;

  //////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////

  assign is_signed = (fu.op == OP_DIV) || (fu.op == OP_REM);
  assign want_rem  = (fu.op == OP_REM) || (fu.op == OP_REMU);

  assign a_neg  = is_signed & fu.operand_a[XLEN-1];
  assign b_neg  = is_signed & fu.operand_b[XLEN-1];
  assign b_zero = (fu.operand_b == '0);

  // Most negative value stays 2^(XLEN-1) as unsigned, which divides correctly
  assign a_abs = a_neg ? -fu.operand_a : fu.operand_a;
  assign b_abs = b_neg ? -fu.operand_b : fu.operand_b;

  // FSM events
  assign load      = (state_q == DIV_IDLE) && fu.req && !b_zero;
  assign zero_done = (state_q == DIV_IDLE) && fu.req && b_zero;
  assign step      = (state_q == DIV_RUN) && (cnt_q != CNT_W'(STEPS));
  assign finish    = (state_q == DIV_RUN) && (cnt_q == CNT_W'(STEPS));

  //////////////////////////////////////////////////
  // Shift-subtract step and sign correction
  //////////////////////////////////////////////////

  // Next dividend bit shifted into the partial remainder
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign trial   = {1'b0, shifted} - {2'b00, dvs_q};

  assign q_fix = q_neg_q ? -quo_q : quo_q;
  assign r_fix = r_neg_q ? -rem_q : rem_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        DIV_IDLE: begin
          cnt_q <= '0;
          if (zero_done) begin
            state_q <= DIV_DONE;
          end else if (load) begin
            state_q <= DIV_RUN;
          end
        end
        DIV_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (finish) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          if (fu.res_ready) begin
            state_q <= DIV_IDLE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rem_q   <= '0;
      quo_q   <= a_abs;
      dvs_q   <= b_abs;
      q_neg_q <= a_neg ^ b_neg;
      // Remainder takes the sign of the dividend
      r_neg_q <= a_neg;
    end
    if (step) begin
      // Restore on a negative trial, keep the difference otherwise
      rem_q <= trial[XLEN+1] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
      quo_q <= {quo_q[XLEN-2:0], !trial[XLEN+1]};
    end
    // Zero divisor gives all ones or the dividend
    if (zero_done) begin
      result_q <= want_rem ? fu.operand_a : '1;
    end else if (finish) begin
      result_q <= want_rem ? r_fix : q_fix;
    end
  end

  assign fu.res_valid = (state_q == DIV_DONE);
  assign fu.result    = result_q;

endmodule

// File: source/ex_fu_if.sv
// Functional unit interface
// Request, operator, operands and result handshake of one multi-cycle unit
// Modports for the stage side and the unit side

`include "ex_consts.svh"

interface ex_fu_if #(
  parameter type op_t = logic [1:0]
);

  // Stage side, held stable from start to result handshake
  logic                req;
  op_t                 op;
  logic [`EX_XLEN-1:0] operand_a;
  logic [`EX_XLEN-1:0] operand_b;
  logic                res_ready;

  // Unit side, result held until res_ready
  logic                res_valid;
  logic [`EX_XLEN-1:0] result;

  modport stage (
    output req,
    output op,
    output operand_a,
    output operand_b,
    output res_ready,
    input  res_valid,
    input  result
  );

  modport unit (
    input  req,
    input  op,
    input  operand_a,
    input  operand_b,
    input  res_ready,
    output res_valid,
    output result
  );

endinterface

// File: source/ex_mult.sv
// Two-cycle 32x32 multiplier
// Stage one registers four 16x16 partial products
// Stage two sums them and picks the low or high word
// Result held until accepted

`include "ex_consts.svh"

module ex_mult (
  input  logic   clk,
  input  logic   rst_n,
  ex_fu_if.unit  fu
);
  import ex_pkg::*;

  localparam int XLEN = `EX_XLEN;
  localparam int HW   = `EX_XLEN / 2;

  logic                    a_signed;
  logic                    b_signed;
  logic signed [HW:0]      a_hi;
  logic signed [HW:0]      a_lo;
  logic signed [HW:0]      b_hi;
  logic signed [HW:0]      b_lo;
  logic signed [2*HW+1:0]  pp_ll;
  logic signed [2*HW+1:0]  pp_lh;
  logic signed [2*HW+1:0]  pp_hl;
  logic signed [2*HW+1:0]  pp_hh;
  logic signed [2*XLEN-1:0] product;
  logic                    start;
  logic                    pp_valid_q;
  logic                    res_valid_q;
  logic [XLEN-1:0]         result_q;

  // Operand signedness per operator
  assign a_signed = (fu.op == OP_MULH) || (fu.op == OP_MULHSU);
  assign b_signed = (fu.op == OP_MULH);

  // Upper halves carry the sign, lower halves are always positive
  assign a_hi = {a_signed & fu.operand_a[XLEN-1], fu.operand_a[XLEN-1:HW]};
  assign a_lo = {1'b0, fu.operand_a[HW-1:0]};
  assign b_hi = {b_signed & fu.operand_b[XLEN-1], fu.operand_b[XLEN-1:HW]};
  assign b_lo = {1'b0, fu.operand_b[HW-1:0]};

  // Only start when both stages are empty
  assign start = fu.req && !pp_valid_q && !res_valid_q;

  // Weighted sum of the partial products, signed throughout
  assign product = pp_ll + (pp_lh <<< HW) + (pp_hl <<< HW) + (pp_hh <<< (2 * HW));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pp_valid_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      pp_valid_q <= start;
      // Hold flag set by stage two, cleared by the result handshake
      if (pp_valid_q) begin
        res_valid_q <= 1'b1;
      end else if (res_valid_q && fu.res_ready) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      pp_ll <= a_lo * b_lo;
      pp_lh <= a_lo * b_hi;
      pp_hl <= a_hi * b_lo;
      pp_hh <= a_hi * b_hi;
    end
    if (pp_valid_q) begin
      result_q <= (fu.op == OP_MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
    end
  end

  assign fu.res_valid = res_valid_q;
  assign fu.result    = result_q;

endmodule

// File: source/ex_pkg.sv
// Execute stage package
// Operator enums for ALU, multiplier and divider
// Write port result select type

package ex_pkg;

  // ALU operators, shared adder for arithmetic and compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // Branch comparisons
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators, MUL is the low word, the rest the high word
  typedef enum logic [1:0] {
    OP_MUL    = 2'd0,
    OP_MULH   = 2'd1,
    OP_MULHU  = 2'd2,
    OP_MULHSU = 2'd3
  } mul_op_e;

  // Divider operators
  typedef enum logic [1:0] {
    OP_DIV  = 2'd0,
    OP_DIVU = 2'd1,
    OP_REM  = 2'd2,
    OP_REMU = 2'd3
  } div_op_e;

  // Source of the write port data
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MUL = 2'd1,
    RES_DIV = 2'd2
  } res_sel_e;

endpackage

// File: source/ex_stage.sv
// Execute stage top level
// ALU, multiplier and divider instances
// Result select, stage ready/valid flow control
// EX/WB pipeline register

`include "ex_consts.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,

  // ID side
  input  logic                   id_valid_i,
  input  logic                   alu_en_i,
  input  logic                   mul_en_i,
  input  logic                   div_en_i,
  input  ex_pkg::alu_op_e        alu_op_i,
  input  ex_pkg::mul_op_e        mul_op_i,
  input  ex_pkg::div_op_e        div_op_i,
  input  logic [`EX_XLEN-1:0]    operand_a_i,
  input  logic [`EX_XLEN-1:0]    operand_b_i,
  input  logic                   rf_we_i,
  input  logic [`EX_REG_AW-1:0]  rf_waddr_i,
  output logic                   ex_ready_o,

  // WB side
  input  logic                   wb_ready_i,
  output logic                   wb_valid_o,
  output logic                   wb_rf_we_o,
  output logic [`EX_REG_AW-1:0]  wb_rf_waddr_o,
  output logic [`EX_XLEN-1:0]    wb_rf_wdata_o,
  output logic                   wb_branch_taken_o
);
  import ex_pkg::*;

  res_sel_e              res_sel;
  logic [`EX_XLEN-1:0]   alu_result;
  logic                  alu_cmp;
  logic [`EX_XLEN-1:0]   res_data;
  logic                  unit_done;
  logic                  ex_valid;
  logic                  ex_fire;
  logic                  branch_op;
  logic                  branch_taken;

  ex_fu_if #(.op_t(mul_op_e)) mul_if ();
  ex_fu_if #(.op_t(div_op_e)) div_if ();

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .alu_op_i     (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // Requests only while ID offers a valid instruction for the unit
  assign mul_if.req       = id_valid_i && mul_en_i;
  assign mul_if.op        = mul_op_i;
  assign mul_if.operand_a = operand_a_i;
  assign mul_if.operand_b = operand_b_i;
  assign mul_if.res_ready = wb_ready_i;

  assign div_if.req       = id_valid_i && div_en_i;
  assign div_if.op        = div_op_i;
  assign div_if.operand_a = operand_a_i;
  assign div_if.operand_b = operand_b_i;
  assign div_if.res_ready = wb_ready_i;

  ex_mult u_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .fu    (mul_if.unit)
  );

  ex_div u_div (
    .clk   (clk),
    .rst_n (rst_n),
    .fu    (div_if.unit)
  );

  //////////////////////////////////////////////////
  // Result select and flow control
  //////////////////////////////////////////////////

  // One enable per instruction, ALU as fallback
  always_comb begin
    if (alu_en_i) begin
      res_sel = RES_ALU;
    end else if (mul_en_i) begin
      res_sel = RES_MUL;
    end else if (div_en_i) begin
      res_sel = RES_DIV;
    end else begin
      res_sel = RES_ALU;
    end
  end

  always_comb begin
    unique case (res_sel)
      RES_MUL: begin
        res_data  = mul_if.result;
        unit_done = mul_if.res_valid;
      end
      RES_DIV: begin
        res_data  = div_if.result;
        unit_done = div_if.res_valid;
      end
      // ALU result is valid in the same cycle
      default: begin
        res_data  = alu_result;
        unit_done = 1'b1;
      end
    endcase
  end

  assign ex_valid   = id_valid_i && unit_done;
  assign ex_ready_o = !id_valid_i || (unit_done && wb_ready_i);
  // Instruction leaves EX into the EX/WB register
  assign ex_fire    = ex_valid && wb_ready_i;

  // Taken flag only for the six branch compares
  assign branch_op = (alu_op_i == ALU_EQ) || (alu_op_i == ALU_NE) ||
                     (alu_op_i == ALU_LT) || (alu_op_i == ALU_GE) ||
                     (alu_op_i == ALU_LTU) || (alu_op_i == ALU_GEU);
  assign branch_taken = alu_en_i && branch_op && alu_cmp;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o <= 1'b0;
      wb_rf_we_o <= 1'b0;
    end else if (ex_fire) begin
      wb_valid_o <= 1'b1;
      wb_rf_we_o <= rf_we_i;
    end else if (wb_ready_i) begin
      // Bubble when WB takes and nothing completes
      wb_valid_o <= 1'b0;
      wb_rf_we_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_fire) begin
      wb_rf_waddr_o     <= rf_waddr_i;
      wb_rf_wdata_o     <= res_data;
      wb_branch_taken_o <= branch_taken;
    end
  end

endmodule
